// File: flist.f
+incdir+include
hdl/temp_pkg.sv
hdl/pipe_multiplier.sv
hdl/restoring_divider.sv
hdl/sample_averager.sv
hdl/adc_to_temp.sv
hdl/temp_sense_top.sv
tb/tb_temp_sense_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_temp_sense_top
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: build
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_temp_sense_top.sv
`timescale 1ns/1ps

module tb_temp_sense_top;
	import temp_pkg::*;

	`include "ntc_table.svh"

	localparam int AVG_LOG2    = 2;
	localparam int MULT_STAGES = 3;
	// output units per 5 degC segment
	localparam int STEP        = 1280;
	localparam int WAIT_LIMIT  = 2000;
	localparam int N_CASES     = 14;
	// stall column value that asks for a random stall
	localparam logic [7:0] RAND_STALL = 8'hFF;

	// four raw readings of one batch plus result stall cycles
	typedef struct packed {
		logic [ADC_W-1:0] c0;
		logic [ADC_W-1:0] c1;
		logic [ADC_W-1:0] c2;
		logic [ADC_W-1:0] c3;
		logic [7:0]       stall;
	} tb_case_s;

	// ---------------------------------------------------------------------------
	// stimulus table with one batch per entry in result order
	// ---------------------------------------------------------------------------
	localparam tb_case_s CASES [N_CASES] = '{
		'{12'd3000, 12'd2900, 12'd2950, 12'd3100, 8'd0},       // colder than table
		'{12'd2852, 12'd2854, 12'd2853, 12'd2853, RAND_STALL}, // coldest breakpoint
		'{12'd100,  12'd120,  12'd138,  12'd150,  RAND_STALL}, // hotter than table
		'{12'd137,  12'd139,  12'd138,  12'd138,  8'd2},       // hottest breakpoint
		'{12'd1740, 12'd1744, 12'd1741, 12'd1743, RAND_STALL}, // 0 C breakpoint
		'{12'd957,  12'd959,  12'd958,  12'd958,  RAND_STALL}, // 20 C breakpoint
		'{12'd160,  12'd158,  12'd159,  12'd159,  8'd3},       // 80 C breakpoint
		'{12'd2700, 12'd2701, 12'd2702, 12'd2704, RAND_STALL}, // first segment
		'{12'd1500, 12'd1503, 12'd1498, 12'd1507, 8'd80},      // long stall
		'{12'd150,  12'd151,  12'd152,  12'd149,  RAND_STALL}, // last segment
		'{12'd800,  12'd811,  12'd805,  12'd799,  RAND_STALL},
		'{12'd400,  12'd410,  12'd403,  12'd391,  8'd1},
		'{12'd2000, 12'd2100, 12'd2050, 12'd1999, RAND_STALL},
		'{12'd1700, 12'd1201, 12'd1555, 12'd999,  8'd5}        // widely spread batch
	};

	logic         clk_50m;
	logic         rst_n;
	logic         adc_valid;
	logic         adc_ready;
	adc_sample_s  adc;
	logic         temp_valid;
	logic         temp_ready;
	temp_result_s temp;

	int seed;
	int stall_len [N_CASES];
	// back-pressure reached the input side
	bit saw_ready_low;
	// input side resumed after a stall
	bit saw_ready_recover;

	temp_sense_top #(
		.AVG_LOG2     (AVG_LOG2),
		.MULT_STAGES  (MULT_STAGES)
	) u_temp_sense_top (
		.i_clk_50m    (clk_50m),
		.i_rst_n      (rst_n),
		.i_adc_valid  (adc_valid),
		.o_adc_ready  (adc_ready),
		.i_adc        (adc),
		.o_temp_valid (temp_valid),
		.i_temp_ready (temp_ready),
		.o_temp       (temp)
	);

	// 50 MHz
	initial begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	// truncated mean then clamp or interpolate against the table
	function automatic temp_result_s expected_result(input tb_case_s c);
		int           sum;
		int           mean;
		int           k;
		int           num;
		int           den;
		temp_result_s r;
		sum  = int'(c.c0) + int'(c.c1) + int'(c.c2) + int'(c.c3);
		mean = sum / 4;
		r    = '0;
		if (mean >= int'(NTC_TABLE[0])) begin
			r.clamp_low = 1'b1;
		end else if (mean <= int'(NTC_TABLE[NTC_POINTS-1])) begin
			r.temp       = TEMP_W'((NTC_POINTS - 1) * STEP);
			r.clamp_high = 1'b1;
		end else begin
			// first breakpoint at or below the mean
			k = 1;
			while (mean < int'(NTC_TABLE[k])) begin
				k++;
			end
			num    = (int'(NTC_TABLE[k-1]) - mean) * STEP;
			den    = int'(NTC_TABLE[k-1]) - int'(NTC_TABLE[k]);
			r.temp = TEMP_W'((k - 1) * STEP + num / den);
		end
		return r;
	endfunction

	// starts on a falling edge and returns on the one after the transfer
	task automatic send_sample(input logic [ADC_W-1:0] count);
		int waited;
		waited    = 0;
		adc_valid = 1'b1;
		adc.count = count;
		// registered ready holds its level through the next rising edge
		while (!adc_ready) begin
			@(negedge clk_50m);
			waited++;
			assert (waited < WAIT_LIMIT) else
				fail_now("timed out waiting for o_adc_ready to accept a sample");
		end
		if (waited > 0) begin
			saw_ready_recover = 1'b1;
		end
		@(negedge clk_50m);
	endtask

	task automatic send_batches();
		for (int i = 0; i < N_CASES; i++) begin
			send_sample(CASES[i].c0);
			send_sample(CASES[i].c1);
			send_sample(CASES[i].c2);
			send_sample(CASES[i].c3);
		end
		adc_valid = 1'b0;
	endtask

	// ---------------------------------------------------------------------------
	// result side stalls then accepts each result in batch order
	// ---------------------------------------------------------------------------
	task automatic collect_results();
		temp_result_s held;
		temp_result_s exp_res;
		int           waited;
		for (int i = 0; i < N_CASES; i++) begin
			exp_res = expected_result(CASES[i]);
			waited  = 0;
			while (!temp_valid) begin
				@(negedge clk_50m);
				waited++;
				assert (waited < WAIT_LIMIT) else
					fail_now($sformatf(
						"timed out waiting for o_temp_valid in case %0d", i));
			end
			held = temp;
			// result must sit unchanged while refused
			for (int s = 0; s < stall_len[i]; s++) begin
				@(negedge clk_50m);
				if (!adc_ready) begin
					saw_ready_low = 1'b1;
				end
				assert (temp_valid && temp == held) else
					fail_now($sformatf("Fail at %0d ns: case %0d result moved during stall",
						$time, i));
			end
			assert (held == exp_res) else
				fail_now($sformatf(
					"Fail at %0d ns: case %0d temp/low/high got %0d/%b/%b exp %0d/%b/%b",
					$time, i, held.temp, held.clamp_low, held.clamp_high,
					exp_res.temp, exp_res.clamp_low, exp_res.clamp_high));
			temp_ready = 1'b1;
			@(negedge clk_50m);
			temp_ready = 1'b0;
		end
	endtask

	initial begin
		seed              = 36102;
		rst_n             = 1'b0;
		adc_valid         = 1'b0;
		adc               = '0;
		temp_ready        = 1'b0;
		saw_ready_low     = 1'b0;
		saw_ready_recover = 1'b0;
		for (int i = 0; i < N_CASES; i++) begin
			if (CASES[i].stall == RAND_STALL) begin
				stall_len[i] = $unsigned($random(seed)) % 6;
			end else begin
				stall_len[i] = int'(CASES[i].stall);
			end
		end
		repeat (16) @(negedge clk_50m);
		rst_n = 1'b1;
		@(negedge clk_50m);
		assert (!temp_valid && adc_ready) else
			fail_now($sformatf("Fail at %0d ns: wrong handshake levels after reset", $time));
		fork
			send_batches();
			collect_results();
		join
		assert (saw_ready_low) else
			fail_now("o_adc_ready never fell while results were held back");
		assert (saw_ready_recover) else
			fail_now("o_adc_ready never rose again after a stall");
		assert (adc_ready && !temp_valid) else
			fail_now($sformatf("Fail at %0d ns: pipeline not empty at the end", $time));
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: hdl/temp_sense_top.sv
`timescale 1ns/1ps

module temp_sense_top #(
	parameter int AVG_LOG2    = 2,
	parameter int MULT_STAGES = 3
) (
	input  logic                   i_clk_50m,
	input  logic                   i_rst_n,
	input  logic                   i_adc_valid,
	output logic                   o_adc_ready,
	input  temp_pkg::adc_sample_s  i_adc,
	output logic                   o_temp_valid,
	input  logic                   i_temp_ready,
	output temp_pkg::temp_result_s o_temp
);
	import temp_pkg::*;

	// averaged mean toward the converter
	logic        avg_valid;
	logic        avg_ready;
	adc_sample_s avg_sample;

	// batch mean of 2**AVG_LOG2 readings
	sample_averager #(
		.AVG_LOG2  (AVG_LOG2)
	) u_sample_averager (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_valid   (i_adc_valid),
		.o_ready   (o_adc_ready),
		.i_sample  (i_adc),
		.o_valid   (avg_valid),
		.i_ready   (avg_ready),
		.o_sample  (avg_sample)
	);

	// table search and interpolation
	adc_to_temp #(
		.MULT_STAGES (MULT_STAGES)
	) u_adc_to_temp (
		.i_clk_50m   (i_clk_50m),
		.i_rst_n     (i_rst_n),
		.i_valid     (avg_valid),
		.o_ready     (avg_ready),
		.i_sample    (avg_sample),
		.o_valid     (o_temp_valid),
		.i_ready     (i_temp_ready),
		.o_result    (o_temp)
	);

endmodule

// File: hdl/adc_to_temp.sv
`timescale 1ns/1ps

module adc_to_temp #(
	parameter int MULT_STAGES = 3
) (
	input  logic                   i_clk_50m,
	input  logic                   i_rst_n,
	input  logic                   i_valid,
	output logic                   o_ready,
	input  temp_pkg::adc_sample_s  i_sample,
	output logic                   o_valid,
	input  logic                   i_ready,
	output temp_pkg::temp_result_s o_result
);
	import temp_pkg::*;

	`include "ntc_table.svh"

	localparam int IDX_W = $clog2(NTC_POINTS);
	// hottest clamp value, 21 segments
	localparam logic [TEMP_W-1:0] TEMP_MAX = TEMP_W'(SEG_STEP * (NTC_POINTS - 1));

	// ---------------------------------------------------------------------------
	// one-hot state bits
	// ---------------------------------------------------------------------------
	localparam int S_IDLE   = 0;
	localparam int S_JUDGE  = 1;
	localparam int S_SEARCH = 2;
	localparam int S_SCALE  = 3;
	localparam int S_BASE   = 4;
	localparam int S_DIVIDE = 5;
	localparam int S_FINISH = 6;
	localparam int N_STATES = 7;

	function automatic logic [N_STATES-1:0] st(input int idx);
		return N_STATES'(1) << idx;
	endfunction

	logic [N_STATES-1:0] r_state;
	logic [ADC_W-1:0]    r_count;
	// segment index, lower breakpoint of the segment
	logic [IDX_W-1:0]    r_idx;
	logic [15:0]         r_mul_a;
	logic                r_mul_vld;
	logic [31:0]         r_dividend;
	logic [15:0]         r_divisor;
	logic                r_div_start;
	// (k-1) * step
	logic [TEMP_W-1:0]   r_base;
	temp_result_s        r_result;

	logic [ADC_W-1:0]    w_seg_hi;
	logic [ADC_W-1:0]    w_seg_lo;
	logic                w_cold;
	logic                w_hot;
	logic                w_seg_hit;
	logic                w_mul_en;
	logic                w_mul_done;
	logic [31:0]         w_mul_p;
	logic                w_div_done;
	logic [15:0]         w_quotient;

	// breakpoints around the current index
	assign w_seg_hi  = NTC_TABLE[r_idx - IDX_W'(1)];
	assign w_seg_lo  = NTC_TABLE[r_idx];
	assign w_cold    = r_count >= NTC_TABLE[0];
	assign w_hot     = r_count <= NTC_TABLE[NTC_POINTS-1];
	assign w_seg_hit = r_count >= w_seg_lo;

	// ---------------------------------------------------------------------------
	// control FSM
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state     <= st(S_IDLE);
			r_idx       <= '0;
			r_mul_vld   <= 1'b0;
			r_div_start <= 1'b0;
		end else begin
			// single cycle strobes
			r_mul_vld   <= 1'b0;
			r_div_start <= 1'b0;
			unique case (1'b1)
				r_state[S_IDLE]: begin
					if (i_valid) begin
						r_state <= st(S_JUDGE);
					end
				end
				r_state[S_JUDGE]: begin
					if (w_cold || w_hot) begin
						r_state <= st(S_FINISH);
					end else begin
						// reading is below table[0], so k starts at 1
						r_idx   <= IDX_W'(1);
						r_state <= st(S_SEARCH);
					end
				end
				r_state[S_SEARCH]: begin
					// one step per cycle, always stops before the last entry
					if (w_seg_hit) begin
						r_mul_vld <= 1'b1;
						r_state   <= st(S_SCALE);
					end else begin
						r_idx <= r_idx + IDX_W'(1);
					end
				end
				r_state[S_SCALE]: begin
					// second pass, k * step
					if (w_mul_done) begin
						r_mul_vld <= 1'b1;
						r_state   <= st(S_BASE);
					end
				end
				r_state[S_BASE]: begin
					if (w_mul_done) begin
						r_div_start <= 1'b1;
						r_state     <= st(S_DIVIDE);
					end
				end
				r_state[S_DIVIDE]: begin
					if (w_div_done) begin
						r_state <= st(S_FINISH);
					end
				end
				r_state[S_FINISH]: begin
					if (i_ready) begin
						r_state <= st(S_IDLE);
					end
				end
				default: r_state <= st(S_IDLE);
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// datapath registers
	// ---------------------------------------------------------------------------
	always_ff @(posedge i_clk_50m) begin
		unique case (1'b1)
			r_state[S_IDLE]: begin
				if (i_valid) begin
					r_count <= i_sample.count;
				end
			end
			r_state[S_JUDGE]: begin
				if (w_cold) begin
					r_result <= '{temp: '0, clamp_low: 1'b1, clamp_high: 1'b0};
				end else if (w_hot) begin
					r_result <= '{temp: TEMP_MAX, clamp_low: 1'b0, clamp_high: 1'b1};
				end
			end
			r_state[S_SEARCH]: begin
				// distance from the colder breakpoint
				if (w_seg_hit) begin
					r_mul_a <= {{(16-ADC_W){1'b0}}, w_seg_hi - r_count};
				end
			end
			r_state[S_SCALE]: begin
				if (w_mul_done) begin
					r_dividend <= w_mul_p;
					r_mul_a    <= {{(16-IDX_W){1'b0}}, r_idx};
				end
			end
			r_state[S_BASE]: begin
				if (w_mul_done) begin
					r_base    <= w_mul_p[TEMP_W-1:0] - SEG_STEP;
					r_divisor <= {{(16-ADC_W){1'b0}}, w_seg_hi - w_seg_lo};
				end
			end
			r_state[S_DIVIDE]: begin
				// fraction of a segment is below one step, no overflow
				if (w_div_done) begin
					r_result <= '{temp: r_base + w_quotient, clamp_low: 1'b0, clamp_high: 1'b0};
				end
			end
			default: ;
		endcase
	end

	// pipeline flushes while busy, parked while idle
	assign w_mul_en = !r_state[S_IDLE];

	pipe_multiplier #(
		.STAGES    (MULT_STAGES)
	) u_pipe_multiplier (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_en      (w_mul_en),
		.i_valid   (r_mul_vld),
		.i_a       (r_mul_a),
		.i_b       (SEG_STEP),
		.o_valid   (w_mul_done),
		.o_p       (w_mul_p)
	);

	restoring_divider u_restoring_divider (
		.i_clk_50m  (i_clk_50m),
		.i_rst_n    (i_rst_n),
		.i_start    (r_div_start),
		.i_dividend (r_dividend),
		.i_divisor  (r_divisor),
		.o_done     (w_div_done),
		.o_quotient (w_quotient)
	);

	assign o_ready  = r_state[S_IDLE];
	assign o_valid  = r_state[S_FINISH];
	assign o_result = r_result;

	a_result_hold: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_valid && !i_ready |=> o_valid && $stable(o_result));

endmodule

// File: hdl/sample_averager.sv
`timescale 1ns/1ps

module sample_averager #(
	parameter int AVG_LOG2 = 2
) (
	input  logic                  i_clk_50m,
	input  logic                  i_rst_n,
	input  logic                  i_valid,
	output logic                  o_ready,
	input  temp_pkg::adc_sample_s i_sample,
	output logic                  o_valid,
	input  logic                  i_ready,
	output temp_pkg::adc_sample_s o_sample
);
	import temp_pkg::*;

	// room for 2**AVG_LOG2 full scale counts
	localparam int SUM_W = ADC_W + AVG_LOG2;

	logic [SUM_W-1:0]    r_sum;
	logic [AVG_LOG2-1:0] r_cnt;
	// accumulator holds a finished batch waiting for the mean slot
	logic                r_full;
	logic                r_out_valid;
	adc_sample_s         r_out;

	logic                w_in_fire;
	logic                w_last;
	logic                w_load_mean;
	logic [SUM_W-1:0]    w_sum_next;
	logic [SUM_W-1:0]    w_mean_src;

	assign w_in_fire  = i_valid && o_ready;
	assign w_last     = w_in_fire && (r_cnt == '1);
	assign w_sum_next = r_sum + SUM_W'(i_sample.count);
	// held batch drains first, else the batch closing this cycle
	assign w_load_mean = (r_full && i_ready) || (w_last && (!r_out_valid || i_ready));
	assign w_mean_src  = r_full ? r_sum : w_sum_next;

	// accumulator and handoff control
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_sum       <= '0;
			r_cnt       <= '0;
			r_full      <= 1'b0;
			r_out_valid <= 1'b0;
		end else begin
			if (w_in_fire) begin
				r_cnt <= r_cnt + 1'b1;
			end
			if (w_load_mean) begin
				r_sum       <= '0;
				r_full      <= 1'b0;
				r_out_valid <= 1'b1;
			end else begin
				if (w_in_fire) begin
					r_sum <= w_sum_next;
				end
				// batch done but mean slot still busy
				if (w_last) begin
					r_full <= 1'b1;
				end
				if (r_out_valid && i_ready) begin
					r_out_valid <= 1'b0;
				end
			end
		end
	end

	// truncated mean
	always_ff @(posedge i_clk_50m) begin
		if (w_load_mean) begin
			r_out.count <= w_mean_src[SUM_W-1:AVG_LOG2];
		end
	end

	// stall only with a full batch behind an occupied mean slot
	assign o_ready  = !r_full;
	assign o_valid  = r_out_valid;
	assign o_sample = r_out;

	a_mean_hold: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_valid && !i_ready |=> o_valid && $stable(o_sample));

endmodule

// File: hdl/restoring_divider.sv
`timescale 1ns/1ps

module restoring_divider (
	input  logic        i_clk_50m,
	input  logic        i_rst_n,
	input  logic        i_start,
	input  logic [31:0] i_dividend,
	input  logic [15:0] i_divisor,
	output logic        o_done,
	output logic [15:0] o_quotient
);

	// ---------------------------------------------------------------------------
	// control
	// ---------------------------------------------------------------------------

	// division in progress
	logic        r_busy;
	// iteration counter, 16 quotient bits
	logic [3:0]  r_bit_cnt;
	// one cycle done pulse
	logic        r_done;

	// ---------------------------------------------------------------------------
	// datapath
	// ---------------------------------------------------------------------------

	// partial remainder, always below the divisor
	logic [15:0] r_rem;
	// dividend low half shifting out, quotient bits shifting in
	logic [15:0] r_quo;
	// remainder with next dividend bit brought down
	logic [16:0] w_rem_shift;
	// trial subtraction, bit 16 set means negative
	logic [16:0] w_trial;

	assign w_rem_shift = {r_rem, r_quo[15]};
	assign w_trial     = w_rem_shift - {1'b0, i_divisor};

	// load on start, then 16 iterations, done after the last
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_busy    <= 1'b0;
			r_bit_cnt <= '0;
			r_done    <= 1'b0;
		end else begin
			r_done <= 1'b0;
			if (i_start) begin
				r_busy    <= 1'b1;
				r_bit_cnt <= '0;
			end else if (r_busy) begin
				r_bit_cnt <= r_bit_cnt + 4'd1;
				if (r_bit_cnt == 4'd15) begin
					r_busy <= 1'b0;
					r_done <= 1'b1;
				end
			end
		end
	end

	// upper dividend half seeds the remainder
	// quotient fits 16 bits since that half is below the divisor
	always_ff @(posedge i_clk_50m) begin
		if (i_start) begin
			r_rem <= i_dividend[31:16];
			r_quo <= i_dividend[15:0];
		end else if (r_busy) begin
			if (w_trial[16]) begin
				// restore, quotient bit 0
				r_rem <= w_rem_shift[15:0];
				r_quo <= {r_quo[14:0], 1'b0};
			end else begin
				r_rem <= w_trial[15:0];
				r_quo <= {r_quo[14:0], 1'b1};
			end
		end
	end

	assign o_done     = r_done;
	assign o_quotient = r_quo;

	a_divisor_nonzero: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_start |-> (i_divisor != 16'd0));

	// start is only legal once the previous division has finished
	a_no_start_busy: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_start |-> !r_busy);

endmodule

// File: hdl/pipe_multiplier.sv
`timescale 1ns/1ps

module pipe_multiplier #(
	parameter int STAGES = 3
) (
	input  logic        i_clk_50m,
	input  logic        i_rst_n,
	input  logic        i_en,
	input  logic        i_valid,
	input  logic [15:0] i_a,
	input  logic [15:0] i_b,
	output logic        o_valid,
	output logic [31:0] o_p
);

	// product chain, stage 0 holds the raw product
	logic [31:0]       r_prod [STAGES];
	// valid bit riding alongside each stage
	logic [STAGES-1:0] r_vld;

	// data path, advances only with the clock enable
	always_ff @(posedge i_clk_50m) begin
		if (i_en) begin
			r_prod[0] <= i_a * i_b;
			for (int s = 1; s < STAGES; s++) begin
				r_prod[s] <= r_prod[s-1];
			end
		end
	end

	// valid chain, same enable as the data
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_vld <= '0;
		end else if (i_en) begin
			r_vld[0] <= i_valid;
			for (int s = 1; s < STAGES; s++) begin
				r_vld[s] <= r_vld[s-1];
			end
		end
	end

	assign o_p     = r_prod[STAGES-1];
	assign o_valid = r_vld[STAGES-1];

	// caller waits for each product before issuing the next one
	a_one_in_flight: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_valid |-> i_en && (r_vld == '0));

endmodule

// File: hdl/temp_pkg.sv
// ---------------------------------------------------------------------------
// shared widths and constants
// ---------------------------------------------------------------------------
package temp_pkg;

	// raw adc count width
	localparam int ADC_W = 12;

	// temperature word, 8 fraction bits, 0 = -20 degC
	localparam int TEMP_W = 16;

	// number of table breakpoints, -20 .. 85 degC
	localparam int NTC_POINTS = 22;

	// output units per 5 degC segment
	localparam logic [TEMP_W-1:0] SEG_STEP = 16'd1280;

	// ---------------------------------------------------------------------------
	// payload structs
	// ---------------------------------------------------------------------------

	// one adc reading or averaged mean
	typedef struct packed {
		logic [ADC_W-1:0] count;
	} adc_sample_s;

	// converted result, 18 bits
	typedef struct packed {
		// offset fixed point temperature
		logic [TEMP_W-1:0] temp;
		// reading colder than the table
		logic              clamp_low;
		// reading hotter than the table
		logic              clamp_high;
	} temp_result_s;

endpackage

// File: include/ntc_table.svh
// thermistor divider counts at each breakpoint
// counts fall as temperature rises
// included inside a module body after the temp_pkg import,
// so every user gets its own copy of the table
localparam logic [ADC_W-1:0] NTC_TABLE [NTC_POINTS] = '{
	12'd2853, // -20 C
	12'd2558, // -15 C
	12'd2271, // -10 C
	12'd1997, //  -5 C
	12'd1742, //   0 C
	12'd1510, //   5 C
	12'd1302, //  10 C
	12'd1118, //  15 C
	12'd958,  //  20 C
	12'd820,  //  25 C
	12'd701,  //  30 C
	12'd599,  //  35 C
	12'd513,  //  40 C
	12'd439,  //  45 C
	12'd377,  //  50 C
	12'd325,  //  55 C
	12'd280,  //  60 C
	12'd242,  //  65 C
	12'd209,  //  70 C
	12'd181,  //  75 C
	12'd159,  //  80 C
	12'd138   //  85 C
};
